// File: rtl/mipsCtrlPkg.sv
package mipsCtrlPkg;

	typedef logic [5:0] opcode_t;   // instruction bits 31:26
	typedef logic [5:0] funct_t;    // r-type bits 5:0

	typedef enum logic [3:0] {
		ADD,
		AND,
		SUB,
		XOR,
		NOP,
		BREAK,
		BEQ,
		BNE,
		LW,
		SW,
		LUI,
		J
	} instrClass_t;

	typedef enum logic [4:0] {
		RESET,
		FETCH,
		DECODE,
		ALU_EXEC,
		R_WRITE,
		BRANCH_EQ,
		BRANCH_NE,
		JUMP,
		LUI_WRITE,
		LW_ADDR,
		LW_READ,
		LW_WRITE,
		SW_ADDR,
		SW_WRITE,
		NOP_DONE,
		HALT
	} ctrlState_t;

	typedef logic [2:0] aluSel_t;
	typedef logic [1:0] memToReg_t;
	typedef logic [1:0] pcSource_t;
	typedef logic [1:0] aluSrcB_t;

	localparam aluSel_t ALU_NONE = 3'd0;
	localparam aluSel_t ALU_ADD = 3'd1;
	localparam aluSel_t ALU_SUB = 3'd2;
	localparam aluSel_t ALU_AND = 3'd3;
	localparam aluSel_t ALU_XOR = 3'd6;

	localparam memToReg_t WB_ALUOUT = 2'd0;
	localparam memToReg_t WB_MDR = 2'd1;
	localparam memToReg_t WB_IMM = 2'd2;    // upper immediate

	localparam pcSource_t PC_ALU = 2'd0;    // pc + 4 straight from the alu
	localparam pcSource_t PC_ALUOUT = 2'd1; // branch target held in aluout
	localparam pcSource_t PC_JUMP = 2'd2;

	localparam aluSrcB_t SRCB_REG = 2'd0;
	localparam aluSrcB_t SRCB_FOUR = 2'd1;
	localparam aluSrcB_t SRCB_SIGNEXT = 2'd2;
	localparam aluSrcB_t SRCB_BRANCHOFF = 2'd3; // sign extended, shifted by 2

	localparam opcode_t OP_RTYPE = 6'h00;
	localparam opcode_t OP_J = 6'h02;
	localparam opcode_t OP_BEQ = 6'h04;
	localparam opcode_t OP_BNE = 6'h05;
	localparam opcode_t OP_LUI = 6'h0f;
	localparam opcode_t OP_LW = 6'h23;
	localparam opcode_t OP_SW = 6'h2b;

	localparam funct_t FN_NOP = 6'h00;
	localparam funct_t FN_BREAK = 6'h0d;
	localparam funct_t FN_ADD = 6'h20;
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_XOR = 6'h26;

	typedef struct packed {
		aluSel_t aluSel;
		memToReg_t memToReg;
		pcSource_t pcSource;
		logic aluSrcA;      // 0 pc, 1 register a
		aluSrcB_t aluSrcB;
		logic iorD;         // 0 instruction address, 1 data address
		logic regDst;       // 0 rt, 1 rd
	} muxSelect_t;

	typedef struct packed {
		logic pcWrite;
		logic pcWriteCond;
		logic wr;
		logic irWrite;
		logic regWrite;
		logic aLoad;
		logic bLoad;
		logic mdrLoad;
		logic aluOutLoad;
	} regEnables_t;

	typedef struct packed {
		logic regReset;
		logic aReset;
		logic bReset;
		logic pcReset;
		logic mdrReset;
		logic aluOutReset;
		logic irReset;
	} regResets_t;

endpackage : mipsCtrlPkg

// File: rtl/instrDecoder.sv
module instrDecoder(
	input mipsCtrlPkg::opcode_t op,
	input mipsCtrlPkg::funct_t funct,
	output mipsCtrlPkg::instrClass_t instrClass
);

	import mipsCtrlPkg::*;

	instrClass_t rClass;

	// function field only matters for r-type
	always_comb
	begin
		case (funct)
			FN_ADD:
				rClass = ADD;
			FN_AND:
				rClass = AND;
			FN_SUB:
				rClass = SUB;
			FN_XOR:
				rClass = XOR;
			FN_BREAK:
				rClass = BREAK;
			default:
				rClass = NOP;   // FN_NOP and unknown codes
		endcase
	end

	always_comb
	begin
		case (op)
			OP_RTYPE:
				instrClass = rClass;
			OP_BEQ:
				instrClass = BEQ;
			OP_BNE:
				instrClass = BNE;
			OP_LW:
				instrClass = LW;
			OP_SW:
				instrClass = SW;
			OP_LUI:
				instrClass = LUI;
			OP_J:
				instrClass = J;
			default:
				instrClass = NOP;   // unknown opcode runs as nop
		endcase
	end

endmodule : instrDecoder

// File: rtl/stateSequencer.sv
module stateSequencer #(
	parameter int MemReadCycles = 3,
	parameter int MemWriteCycles = 2
)(
	input logic Clk,
	input logic Reset_signal,
	input mipsCtrlPkg::instrClass_t instrClass,
	output mipsCtrlPkg::ctrlState_t state,
	output logic lastWait
);

	import mipsCtrlPkg::*;

	localparam int CntMax = (MemReadCycles > MemWriteCycles) ? MemReadCycles : MemWriteCycles;
	localparam int CntWidth = $clog2(CntMax + 1);

	ctrlState_t nextState;
	logic [CntWidth-1:0] waitCnt;   // cycles spent in the current memory state
	logic memState;

	assign memState = (state == FETCH) || (state == LW_READ) || (state == SW_WRITE);

	always_comb
	begin
		case (state)
			FETCH, LW_READ:
				lastWait = (waitCnt == CntWidth'(MemReadCycles - 1));
			SW_WRITE:
				lastWait = (waitCnt == CntWidth'(MemWriteCycles - 1));
			default:
				lastWait = 1'b0;
		endcase
	end

	always_comb
	begin
		nextState = state;
		case (state)
			RESET:
				nextState = FETCH;
			FETCH:
				if (lastWait)
					nextState = DECODE;
			DECODE:
			begin
				case (instrClass)
					ADD, AND, SUB, XOR:
						nextState = ALU_EXEC;
					BREAK:
						nextState = HALT;
					BEQ:
						nextState = BRANCH_EQ;
					BNE:
						nextState = BRANCH_NE;
					J:
						nextState = JUMP;
					LUI:
						nextState = LUI_WRITE;
					LW:
						nextState = LW_ADDR;
					SW:
						nextState = SW_ADDR;
					default:
						nextState = NOP_DONE;
				endcase
			end
			ALU_EXEC:
				nextState = R_WRITE;
			R_WRITE, BRANCH_EQ, BRANCH_NE, JUMP, LUI_WRITE, LW_WRITE, NOP_DONE:
				nextState = FETCH;
			LW_ADDR:
				nextState = LW_READ;
			LW_READ:
				if (lastWait)
					nextState = LW_WRITE;
			SW_ADDR:
				nextState = SW_WRITE;
			SW_WRITE:
				if (lastWait)
					nextState = FETCH;
			HALT:
				nextState = HALT;   // only reset gets out
			default:
				nextState = RESET;
		endcase
	end

	always_ff @(posedge Clk or posedge Reset_signal)
	begin
		if (Reset_signal)
			state <= RESET;
		else
			state <= nextState;
	end

	// restarts on every state change so each memory stay counts from zero
	always_ff @(posedge Clk or posedge Reset_signal)
	begin
		if (Reset_signal)
			waitCnt <= '0;
		else if (nextState != state)
			waitCnt <= '0;
		else if (memState)
			waitCnt <= waitCnt + 1'b1;
	end

	stateDefined: assert property (@(posedge Clk) disable iff (Reset_signal)
		!$isunknown(state) && (state inside {RESET, FETCH, DECODE, ALU_EXEC, R_WRITE,
			BRANCH_EQ, BRANCH_NE, JUMP, LUI_WRITE, LW_ADDR, LW_READ, LW_WRITE,
			SW_ADDR, SW_WRITE, NOP_DONE, HALT}));

	haltHolds: assert property (@(posedge Clk) disable iff (Reset_signal)
		(state == HALT) |=> (state == HALT));

endmodule : stateSequencer

// File: rtl/controlWordGen.sv
module controlWordGen(
	input logic Clk,
	input logic Reset_signal,
	input mipsCtrlPkg::ctrlState_t state,
	input logic lastWait,
	input mipsCtrlPkg::instrClass_t instrClass,
	input logic aluZero,
	output mipsCtrlPkg::muxSelect_t muxSel,
	output mipsCtrlPkg::regEnables_t enables,
	output mipsCtrlPkg::regResets_t resets,
	output logic pcLoad
);

	import mipsCtrlPkg::*;

	aluSel_t execOp;    // alu code of the r-type being executed
	logic branchTaken;

	// op and funct are gone after decode, so keep the alu code
	always_ff @(posedge Clk or posedge Reset_signal)
	begin
		if (Reset_signal)
			execOp <= ALU_NONE;
		else if (state == DECODE)
		begin
			case (instrClass)
				ADD:
					execOp <= ALU_ADD;
				AND:
					execOp <= ALU_AND;
				SUB:
					execOp <= ALU_SUB;
				XOR:
					execOp <= ALU_XOR;
				default:
					execOp <= ALU_NONE;
			endcase
		end
	end

	always_comb
	begin
		muxSel.aluSel = ALU_NONE;
		muxSel.memToReg = WB_ALUOUT;
		muxSel.pcSource = PC_ALU;
		muxSel.aluSrcA = 1'b0;
		muxSel.aluSrcB = SRCB_REG;
		muxSel.iorD = 1'b0;
		muxSel.regDst = 1'b0;
		enables = '0;
		resets = '0;
		case (state)
			RESET:
				resets = '1;    // clear every datapath register
			FETCH:
			begin
				enables.irWrite = 1'b1;
				enables.mdrLoad = 1'b1;
				muxSel.aluSrcB = SRCB_FOUR;
				if (lastWait)
				begin
					muxSel.aluSel = ALU_ADD;    // pc + 4 on the last read cycle
					enables.pcWrite = 1'b1;
				end
			end
			DECODE:
			begin
				muxSel.aluSel = ALU_ADD;    // branch target into aluout
				muxSel.aluSrcB = SRCB_BRANCHOFF;
				enables.aLoad = 1'b1;
				enables.bLoad = 1'b1;
				enables.aluOutLoad = 1'b1;
			end
			ALU_EXEC:
			begin
				muxSel.aluSel = execOp;
				muxSel.aluSrcA = 1'b1;
				enables.aluOutLoad = 1'b1;
			end
			R_WRITE:
			begin
				muxSel.regDst = 1'b1;   // rd
				enables.regWrite = 1'b1;
			end
			BRANCH_EQ, BRANCH_NE:
			begin
				muxSel.aluSel = ALU_SUB;    // compare a and b
				muxSel.pcSource = PC_ALUOUT;
				muxSel.aluSrcA = 1'b1;
				enables.pcWriteCond = 1'b1;
			end
			JUMP:
			begin
				muxSel.aluSel = ALU_ADD;
				muxSel.pcSource = PC_JUMP;
				muxSel.aluSrcB = SRCB_BRANCHOFF;
				muxSel.iorD = 1'b1;
				enables.pcWrite = 1'b1;
				enables.aluOutLoad = 1'b1;
			end
			LUI_WRITE:
			begin
				muxSel.memToReg = WB_IMM;
				enables.regWrite = 1'b1;    // into rt
			end
			LW_ADDR, SW_ADDR:
			begin
				muxSel.aluSel = ALU_ADD;    // base + offset
				muxSel.aluSrcA = 1'b1;
				muxSel.aluSrcB = SRCB_SIGNEXT;
				enables.aluOutLoad = 1'b1;
			end
			LW_READ:
			begin
				muxSel.iorD = 1'b1;
				enables.mdrLoad = 1'b1;
			end
			LW_WRITE:
			begin
				muxSel.memToReg = WB_MDR;
				enables.regWrite = 1'b1;
			end
			SW_WRITE:
			begin
				muxSel.iorD = 1'b1;
				enables.wr = 1'b1;
			end
			default:
			begin
				// nop and halt keep the datapath idle
			end
		endcase
	end

	assign branchTaken = (state == BRANCH_NE) ? ~aluZero : aluZero;
	assign pcLoad = enables.pcWrite | (enables.pcWriteCond & branchTaken);

	noWriteClash: assert property (@(posedge Clk) disable iff (Reset_signal)
		!(enables.wr && enables.regWrite));

	condOnlyInBranch: assert property (@(posedge Clk) disable iff (Reset_signal)
		enables.pcWriteCond |-> (state inside {BRANCH_EQ, BRANCH_NE}));

endmodule : controlWordGen

// File: rtl/mipsControl.sv
module mipsControl #(
	parameter int MemReadCycles = 3,
	parameter int MemWriteCycles = 2
)(
	input logic Clk,
	input logic Reset_signal,
	input mipsCtrlPkg::opcode_t op,
	input mipsCtrlPkg::funct_t funct,
	input logic aluZero,
	output mipsCtrlPkg::muxSelect_t muxSel,
	output mipsCtrlPkg::regEnables_t enables,
	output mipsCtrlPkg::regResets_t resets,
	output logic pcLoad,
	output mipsCtrlPkg::ctrlState_t stateOut
);

	import mipsCtrlPkg::*;

	instrClass_t instrClass;
	logic lastWait;

	instrDecoder decoder (
		.op(op),
		.funct(funct),
		.instrClass(instrClass)
	);

	stateSequencer #(
		.MemReadCycles(MemReadCycles),
		.MemWriteCycles(MemWriteCycles)
	) sequencer (
		.Clk(Clk),
		.Reset_signal(Reset_signal),
		.instrClass(instrClass),
		.state(stateOut),   // state code goes straight out
		.lastWait(lastWait)
	);

	controlWordGen wordGen (
		.Clk(Clk),
		.Reset_signal(Reset_signal),
		.state(stateOut),
		.lastWait(lastWait),
		.instrClass(instrClass),
		.aluZero(aluZero),
		.muxSel(muxSel),
		.enables(enables),
		.resets(resets),
		.pcLoad(pcLoad)
	);

endmodule : mipsControl

// File: test/controlModel.svh
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

ctrlState_t expState[$];    // expected state, one entry per cycle
bit expLast[$];             // final cycle of a memory stay

function automatic instrClass_t classOf(input opcode_t opIn, input funct_t fnIn);
	instrClass_t c;
	c = NOP;    // unknown codes run as nop
	case (opIn)
		OP_RTYPE:
		begin
			case (fnIn)
				FN_ADD: c = ADD;
				FN_AND: c = AND;
				FN_SUB: c = SUB;
				FN_XOR: c = XOR;
				FN_BREAK: c = BREAK;
				default: c = NOP;
			endcase
		end
		OP_BEQ: c = BEQ;
		OP_BNE: c = BNE;
		OP_LW: c = LW;
		OP_SW: c = SW;
		OP_LUI: c = LUI;
		OP_J: c = J;
		default: c = NOP;
	endcase
	return c;
endfunction

task automatic pushStay(input ctrlState_t st, input int cycles, input bit memStay);
	for (int i = 0; i < cycles; i++)
	begin
		expState.push_back(st);
		expLast.push_back(memStay && (i == cycles - 1));
	end
endtask

// whole instruction from the first fetch cycle
task automatic buildSequence(input instrClass_t cls);
	expState.delete();
	expLast.delete();
	pushStay(FETCH, MemReadCycles, 1'b1);
	pushStay(DECODE, 1, 1'b0);
	case (cls)
		ADD, AND, SUB, XOR:
		begin
			pushStay(ALU_EXEC, 1, 1'b0);
			pushStay(R_WRITE, 1, 1'b0);
		end
		BEQ: pushStay(BRANCH_EQ, 1, 1'b0);
		BNE: pushStay(BRANCH_NE, 1, 1'b0);
		J: pushStay(JUMP, 1, 1'b0);
		LUI: pushStay(LUI_WRITE, 1, 1'b0);
		LW:
		begin
			pushStay(LW_ADDR, 1, 1'b0);
			pushStay(LW_READ, MemReadCycles, 1'b1);
			pushStay(LW_WRITE, 1, 1'b0);
		end
		SW:
		begin
			pushStay(SW_ADDR, 1, 1'b0);
			pushStay(SW_WRITE, MemWriteCycles, 1'b1);
		end
		BREAK: pushStay(HALT, HaltCycles, 1'b0);   // observation window only
		default: pushStay(NOP_DONE, 1, 1'b0);
	endcase
endtask

function automatic muxSelect_t expectedMux(input ctrlState_t st, input bit last,
		input instrClass_t cls);
	muxSelect_t m;
	m = '0;
	case (st)
		FETCH:
		begin
			m.aluSrcB = SRCB_FOUR;
			if (last)
				m.aluSel = ALU_ADD;
		end
		DECODE:
		begin
			m.aluSel = ALU_ADD;
			m.aluSrcB = SRCB_BRANCHOFF;
		end
		ALU_EXEC:
		begin
			m.aluSrcA = 1'b1;
			case (cls)
				ADD: m.aluSel = ALU_ADD;
				AND: m.aluSel = ALU_AND;
				SUB: m.aluSel = ALU_SUB;
				XOR: m.aluSel = ALU_XOR;
				default: m.aluSel = ALU_NONE;
			endcase
		end
		R_WRITE: m.regDst = 1'b1;
		BRANCH_EQ, BRANCH_NE:
		begin
			m.aluSel = ALU_SUB;
			m.pcSource = PC_ALUOUT;
			m.aluSrcA = 1'b1;
		end
		JUMP:
		begin
			m.aluSel = ALU_ADD;
			m.pcSource = PC_JUMP;
			m.aluSrcB = SRCB_BRANCHOFF;
			m.iorD = 1'b1;
		end
		LUI_WRITE: m.memToReg = WB_IMM;
		LW_ADDR, SW_ADDR:
		begin
			m.aluSel = ALU_ADD;
			m.aluSrcA = 1'b1;
			m.aluSrcB = SRCB_SIGNEXT;
		end
		LW_READ, SW_WRITE: m.iorD = 1'b1;
		LW_WRITE: m.memToReg = WB_MDR;
		default: m = '0;
	endcase
	return m;
endfunction

function automatic regEnables_t expectedEnables(input ctrlState_t st, input bit last);
	regEnables_t e;
	e = '0;
	case (st)
		FETCH:
		begin
			e.irWrite = 1'b1;
			e.mdrLoad = 1'b1;
			e.pcWrite = last;   // pc moves on the last read cycle only
		end
		DECODE:
		begin
			e.aLoad = 1'b1;
			e.bLoad = 1'b1;
			e.aluOutLoad = 1'b1;
		end
		ALU_EXEC, LW_ADDR, SW_ADDR: e.aluOutLoad = 1'b1;
		R_WRITE, LUI_WRITE, LW_WRITE: e.regWrite = 1'b1;
		BRANCH_EQ, BRANCH_NE: e.pcWriteCond = 1'b1;
		JUMP:
		begin
			e.pcWrite = 1'b1;
			e.aluOutLoad = 1'b1;
		end
		LW_READ: e.mdrLoad = 1'b1;
		SW_WRITE: e.wr = 1'b1;
		default: e = '0;
	endcase
	return e;
endfunction

function automatic regResets_t expectedResets(input ctrlState_t st);
	return (st == RESET) ? '1 : '0;
endfunction

function automatic logic expectedPcLoad(input ctrlState_t st, input bit last,
		input logic zero);
	logic p;
	p = 1'b0;
	case (st)
		FETCH:
			p = last;   // pc + 4 once the read is done
		JUMP:
			p = 1'b1;
		BRANCH_EQ:
			p = zero;   // taken on equal operands
		BRANCH_NE:
			p = !zero;
		default:
			p = 1'b0;
	endcase
	return p;
endfunction

`endif

// File: test/controlTb.sv
module controlTb;

	import mipsCtrlPkg::*;

	localparam int MemReadCycles = 3;
	localparam int MemWriteCycles = 2;
	localparam int ClkPeriod = 20;
	localparam int NumInstr = 300;
	localparam int MaxInstrCycles = 9;  // lw with the default wait
	localparam int HaltCycles = 20;

	logic Clk;
	logic Reset_signal;
	opcode_t op;
	funct_t funct;
	logic aluZero;
	muxSelect_t muxSel;
	regEnables_t enables;
	regResets_t resets;
	logic pcLoad;
	ctrlState_t stateOut;

	logic [31:0] rngState;
	opcode_t nextOp;
	funct_t nextFunct;

	`include "controlModel.svh"

	mipsControl #(
		.MemReadCycles(MemReadCycles),
		.MemWriteCycles(MemWriteCycles)
	) DUT (
		.Clk(Clk),
		.Reset_signal(Reset_signal),
		.op(op),
		.funct(funct),
		.aluZero(aluZero),
		.muxSel(muxSel),
		.enables(enables),
		.resets(resets),
		.pcLoad(pcLoad),
		.stateOut(stateOut)
	);

	initial
	begin
		Clk = 1'b0;
		forever #(ClkPeriod / 2) Clk = ~Clk;
	end

	// margin of 100 instructions at the longest length
	initial
	begin
		#((NumInstr + 100) * MaxInstrCycles * ClkPeriod);
		$display("Timeout: the control unit did not finish all instructions in time");
		$display("FAIL: see errors above");
		$fatal(1);
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic drawRand(output logic [31:0] r);
		rngState = xorshift(rngState);
		r = rngState;
	endtask

	task automatic checkValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected)
		begin
			$display("Error: %s is %h, expected %h at time %0t", name, actual, expected, $time);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic checkCycle(input ctrlState_t st, input bit last, input instrClass_t cls);
		regEnables_t en;
		en = expectedEnables(st, last);
		checkValue("stateOut", stateOut, st);
		checkValue("muxSel", muxSel, expectedMux(st, last, cls));
		checkValue("enables", enables, en);
		checkValue("resets", resets, expectedResets(st));
		checkValue("pcLoad", pcLoad, expectedPcLoad(st, last, aluZero));
	endtask

	// mostly legal codes, a few unknown ones
	task automatic pickInstr(output opcode_t o, output funct_t f);
		logic [31:0] r;
		drawRand(r);
		o = OP_RTYPE;
		f = FN_NOP;
		case (r[7:0] % 14)
			0: f = FN_ADD;
			1: f = FN_AND;
			2: f = FN_SUB;
			3: f = FN_XOR;
			4: f = FN_NOP;
			5: o = OP_BEQ;
			6: o = OP_BNE;
			7: o = OP_LW;
			8: o = OP_SW;
			9: o = OP_LUI;
			10: o = OP_J;
			11: f = r[13:8];
			12:
			begin
				o = r[21:16];
				f = r[13:8];
			end
			default: f = FN_ADD;
		endcase
		if (classOf(o, f) == BREAK)
			f = FN_NOP; // break only at the very end
	endtask

	task automatic runInstr(input opcode_t o, input funct_t f);
		instrClass_t cls;
		logic [31:0] r;
		cls = classOf(o, f);
		buildSequence(cls);
		for (int idx = 0; idx < expState.size(); idx++)
		begin
			@(posedge Clk);
			#2;
			drawRand(r);
			if (idx == MemReadCycles - 1 || idx == MemReadCycles)
			begin
				op = o;     // last fetch cycle through decode
				funct = f;
			end
			else
			begin
				op = r[13:8];   // junk outside the decode window
				funct = r[21:16];
			end
			aluZero = r[0];
			@(negedge Clk);
			checkCycle(expState[idx], expLast[idx], cls);
		end
	endtask

	initial
	begin
		rngState = 32'h8ef7;
		Reset_signal = 1'b1;
		op = OP_RTYPE;
		funct = FN_NOP;
		aluZero = 1'b0;
		repeat (5)
		begin
			@(negedge Clk);
			checkCycle(RESET, 1'b0, NOP);
		end
		@(posedge Clk);
		#2;
		Reset_signal = 1'b0;
		@(negedge Clk);
		checkCycle(RESET, 1'b0, NOP);   // still reset for one cycle
		for (int n = 0; n < NumInstr; n++)
		begin
			pickInstr(nextOp, nextFunct);
			runInstr(nextOp, nextFunct);
		end
		runInstr(OP_RTYPE, FN_BREAK);
		$display("PASS: all tests");
		$finish;
	end

endmodule : controlTb

// File: list.f
+incdir+test
rtl/mipsCtrlPkg.sv
rtl/instrDecoder.sv
rtl/stateSequencer.sv
rtl/controlWordGen.sv
rtl/mipsControl.sv
test/controlTb.sv
